//--- common/elink_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// E-link shared definitions
// Character types, link widths, comma codes and FIFO sizing
// ~~~~~~~~~~~~~~~~~~~~
package elink_pkg;

  // Encoded symbol and line widths
  localparam int SYM_W       = 10;
  localparam int LINK_W      = 2;
  // Cycles per character on the 2-bit link
  localparam int SLOT_CYCLES = 5;

  // Receive FIFO sizing
  localparam int FIFO_DEPTH  = 16;
  localparam int FIFO_AW     = 4;

  // One character before encoding or after decoding
  typedef struct packed {
    logic       k;
    logic [7:0] data;
  } elink_char_t;

  // One receive FIFO entry
  typedef struct packed {
    logic        code_err;
    elink_char_t ch;
  } elink_rx_word_t;

  typedef enum logic {
    HUNT   = 1'b0,
    LOCKED = 1'b1
  } align_state_e;

  // K28.5 in line order, bit 0 sent first
  localparam logic [SYM_W-1:0] COMMA_NEG = 10'b0101111100;
  localparam logic [SYM_W-1:0] COMMA_POS = 10'b1010000011;

  // Idle character sent in empty slots
  localparam elink_char_t IDLE_CHAR = '{k: 1'b1, data: 8'hBC};

endpackage

//--- elink_tx/enc_8b10b.sv
// ~~~~~~~~~~~~~~~~~~~~
// 8b10b encoder
// 5b6b and 3b4b tables with running disparity, registered symbol
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module enc_8b10b import elink_pkg::*; (
  input  logic             bit_clk_x4,
  input  logic             reset,
  input  elink_char_t      enc_char,
  input  logic             enc_load,
  output logic [SYM_W-1:0] enc_sym
);

  // Running disparity, 1 when positive
  logic             rd;
  logic             rd_mid, rd_next;
  logic [4:0]       x;
  logic [2:0]       y;
  // RD- forms straight from the tables
  logic [5:0]       code6_n, code6;
  logic [3:0]       code4_n, code4;
  logic             bal6, bal4, use_a7;
  logic [SYM_W-1:0] code10, sym_next;

  always_comb begin
    x = enc_char.data[4:0];
    y = enc_char.data[7:5];
    // 5b6b, written as abcdei
    case (x)
      5'd0:  code6_n = 6'b100111;
      5'd1:  code6_n = 6'b011101;
      5'd2:  code6_n = 6'b101101;
      5'd3:  code6_n = 6'b110001;
      5'd4:  code6_n = 6'b110101;
      5'd5:  code6_n = 6'b101001;
      5'd6:  code6_n = 6'b011001;
      5'd7:  code6_n = 6'b111000;
      5'd8:  code6_n = 6'b111001;
      5'd9:  code6_n = 6'b100101;
      5'd10: code6_n = 6'b010101;
      5'd11: code6_n = 6'b110100;
      5'd12: code6_n = 6'b001101;
      5'd13: code6_n = 6'b101100;
      5'd14: code6_n = 6'b011100;
      5'd15: code6_n = 6'b010111;
      5'd16: code6_n = 6'b011011;
      5'd17: code6_n = 6'b100011;
      5'd18: code6_n = 6'b010011;
      5'd19: code6_n = 6'b110010;
      5'd20: code6_n = 6'b001011;
      5'd21: code6_n = 6'b101010;
      5'd22: code6_n = 6'b011010;
      5'd23: code6_n = 6'b111010;
      5'd24: code6_n = 6'b110011;
      5'd25: code6_n = 6'b100110;
      5'd26: code6_n = 6'b010110;
      5'd27: code6_n = 6'b110110;
      5'd28: code6_n = 6'b001110;
      5'd29: code6_n = 6'b101110;
      5'd30: code6_n = 6'b011110;
      default: code6_n = 6'b101011;
    endcase
    // K28 has its own unbalanced 6b form
    if (enc_char.k && x == 5'd28) begin
      code6_n = 6'b001111;
    end
    bal6   = ($countones(code6_n) == 3);
    // D.07 is balanced but still flips with disparity
    code6  = (rd && (!bal6 || x == 5'd7)) ? ~code6_n : code6_n;
    rd_mid = bal6 ? rd : ~rd;

    // Alternate D.x.7 avoids a run of five equal bits
    use_a7 = (!rd_mid && (x inside {5'd17, 5'd18, 5'd20})) ||
             (rd_mid && (x inside {5'd11, 5'd13, 5'd14}));
    // 3b4b, written as fghj
    if (enc_char.k) begin
      case (y)
        3'd0: code4_n = 4'b1011;
        3'd1: code4_n = 4'b0110;
        3'd2: code4_n = 4'b1010;
        3'd3: code4_n = 4'b1100;
        3'd4: code4_n = 4'b1101;
        3'd5: code4_n = 4'b0101;
        3'd6: code4_n = 4'b1001;
        default: code4_n = 4'b0111;
      endcase
    end else begin
      case (y)
        3'd0: code4_n = 4'b1011;
        3'd1: code4_n = 4'b1001;
        3'd2: code4_n = 4'b0101;
        3'd3: code4_n = 4'b1100;
        3'd4: code4_n = 4'b1101;
        3'd5: code4_n = 4'b1010;
        3'd6: code4_n = 4'b0110;
        default: code4_n = use_a7 ? 4'b0111 : 4'b1110;
      endcase
    end
    bal4    = ($countones(code4_n) == 2);
    // Every K 4b form flips, D only when unbalanced or D.x.3
    code4   = (rd_mid && (!bal4 || enc_char.k || y == 3'd3)) ? ~code4_n : code4_n;
    rd_next = bal4 ? rd_mid : ~rd_mid;

    // Bit a goes out first, so it lands in bit 0
    code10 = {code6, code4};
    for (int i = 0; i < SYM_W; i++) begin
      sym_next[i] = code10[SYM_W-1-i];
    end
  end

  // Starts negative after reset
  always_ff @(posedge bit_clk_x4) begin
    if (reset) begin
      rd <= 1'b0;
    end else if (enc_load) begin
      rd <= rd_next;
    end
  end

  always_ff @(posedge bit_clk_x4) begin
    if (enc_load) begin
      enc_sym <= sym_next;
    end
  end

  // Only K28.x and K23/27/29/30.7 exist as control codes
  a_valid_k: assert property (@(posedge bit_clk_x4) disable iff (reset)
    enc_load && enc_char.k |->
      (x == 5'd28) || (enc_char.data inside {8'hF7, 8'hFB, 8'hFD, 8'hFE}));

endmodule

//--- elink_tx/elink_tx_ser.sv
// ~~~~~~~~~~~~~~~~~~~~
// E-link transmit serializer
// One character slot per 5 cycles, idle fill, 2 bits per cycle
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module elink_tx_ser import elink_pkg::*; (
  input  logic              bit_clk_x4,
  input  logic              reset,
  input  elink_char_t       tx_char,
  input  logic              tx_valid,
  output logic              tx_ready,
  output elink_char_t       enc_char,
  output logic              enc_load,
  input  logic [SYM_W-1:0]  enc_sym,
  output logic [LINK_W-1:0] link_data
);

  logic [2:0]       slot;
  logic [SYM_W-1:0] shreg;

  // Slot 0 takes a character, encoder answers in slot 1
  assign tx_ready  = (slot == 3'd0);
  assign enc_load  = tx_ready;
  // Empty slot becomes K28.5
  assign enc_char  = tx_valid ? tx_char : IDLE_CHAR;
  // LSB first on the line
  assign link_data = shreg[LINK_W-1:0];

  always_ff @(posedge bit_clk_x4) begin
    if (reset) begin
      // Wraps to 0 on the first cycle out of reset
      slot  <= 3'(SLOT_CYCLES - 1);
      shreg <= '0;
    end else begin
      slot <= (slot == 3'(SLOT_CYCLES - 1)) ? 3'd0 : slot + 3'd1;
      // Symbol goes out during slots 2,3,4,0,1
      if (slot == 3'd1) begin
        shreg <= enc_sym;
      end else begin
        shreg <= shreg >> LINK_W;
      end
    end
  end

  // Four quiet cycles between slot pulses
  a_slot_period: assert property (@(posedge bit_clk_x4) disable iff (reset)
    tx_ready |=> !tx_ready ##1 !tx_ready ##1 !tx_ready ##1 !tx_ready ##1 tx_ready);

endmodule

//--- elink_rx/elink_rx_deser.sv
// ~~~~~~~~~~~~~~~~~~~~
// E-link receive deserializer
// Comma hunt over all bit offsets, then aligned 10-bit words
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module elink_rx_deser import elink_pkg::*; (
  input  logic              bit_clk_x4,
  input  logic              reset,
  input  logic [LINK_W-1:0] link_data,
  output logic [SYM_W-1:0]  sym,
  output logic              sym_valid,
  output logic              locked
);

  // Oldest bit at position 0
  logic [2*SYM_W-1:0] win;
  align_state_e       state;
  // Chosen offset, 0 or 1 bit into the window
  logic               off;
  logic [2:0]         phase;
  logic [SYM_W-1:0]   win_lo, win_hi;
  logic               hit_lo, hit_hi;
  logic               sym_load, sel_hi;

  assign win_lo = win[SYM_W-1:0];
  assign win_hi = win[SYM_W:1];

  // Two offsets per cycle, window moves 2 bits so 5 cycles cover all 10
  assign hit_lo = (win_lo == COMMA_NEG) || (win_lo == COMMA_POS);
  assign hit_hi = (win_hi == COMMA_NEG) || (win_hi == COMMA_POS);

  assign locked = (state == LOCKED);

  always_comb begin
    if (state == HUNT) begin
      // The comma itself goes out too so the decoder syncs its disparity
      sym_load = hit_lo || hit_hi;
      sel_hi   = !hit_lo;
    end else begin
      sym_load = (phase == 3'(SLOT_CYCLES - 1));
      sel_hi   = off;
    end
  end

  always_ff @(posedge bit_clk_x4) begin
    if (reset) begin
      win       <= '0;
      state     <= HUNT;
      off       <= 1'b0;
      phase     <= '0;
      sym_valid <= 1'b0;
    end else begin
      win       <= {link_data, win[2*SYM_W-1:LINK_W]};
      sym_valid <= sym_load;
      // Phase restarts on every emitted word
      phase     <= sym_load ? 3'd0 : phase + 3'd1;
      // No way back to HUNT short of reset
      if (state == HUNT && sym_load) begin
        state <= LOCKED;
        off   <= sel_hi;
      end
    end
  end

  always_ff @(posedge bit_clk_x4) begin
    if (sym_load) begin
      sym <= sel_hi ? win_hi : win_lo;
    end
  end

endmodule

//--- elink_rx/dec_8b10b.sv
// ~~~~~~~~~~~~~~~~~~~~
// 8b10b decoder
// Code and disparity checks, idle commas dropped
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dec_8b10b import elink_pkg::*; (
  input  logic             bit_clk_x4,
  input  logic             reset,
  input  logic [SYM_W-1:0] sym,
  input  logic             sym_valid,
  output logic             wr_en,
  output elink_rx_word_t   wr_word
);

  // 1 while running disparity is positive
  logic             rd;
  logic             rd_mid, rd_next;
  logic [SYM_W-1:0] code10;
  logic [5:0]       abcdei;
  logic [3:0]       fghj, f4;
  logic [4:0]       x;
  logic [2:0]       y;
  logic [2:0]       ones6, ones4;
  logic             k28, err6, err4, disp_err, code_err;
  elink_char_t      dec_char;

  always_comb begin
    // Bit 0 arrived first and is bit a
    for (int i = 0; i < SYM_W; i++) begin
      code10[SYM_W-1-i] = sym[i];
    end
    abcdei = code10[9:4];
    fghj   = code10[3:0];
    k28    = 1'b0;
    err6   = 1'b0;
    // 6b5b over both disparity forms
    case (abcdei)
      6'b100111, 6'b011000: x = 5'd0;
      6'b011101, 6'b100010: x = 5'd1;
      6'b101101, 6'b010010: x = 5'd2;
      6'b110001:            x = 5'd3;
      6'b110101, 6'b001010: x = 5'd4;
      6'b101001:            x = 5'd5;
      6'b011001:            x = 5'd6;
      6'b111000, 6'b000111: x = 5'd7;
      6'b111001, 6'b000110: x = 5'd8;
      6'b100101:            x = 5'd9;
      6'b010101:            x = 5'd10;
      6'b110100:            x = 5'd11;
      6'b001101:            x = 5'd12;
      6'b101100:            x = 5'd13;
      6'b011100:            x = 5'd14;
      6'b010111, 6'b101000: x = 5'd15;
      6'b011011, 6'b100100: x = 5'd16;
      6'b100011:            x = 5'd17;
      6'b010011:            x = 5'd18;
      6'b110010:            x = 5'd19;
      6'b001011:            x = 5'd20;
      6'b101010:            x = 5'd21;
      6'b011010:            x = 5'd22;
      6'b111010, 6'b000101: x = 5'd23;
      6'b110011, 6'b001100: x = 5'd24;
      6'b100110:            x = 5'd25;
      6'b010110:            x = 5'd26;
      6'b110110, 6'b001001: x = 5'd27;
      6'b001110:            x = 5'd28;
      6'b101110, 6'b010001: x = 5'd29;
      6'b011110, 6'b100001: x = 5'd30;
      6'b101011, 6'b010100: x = 5'd31;
      6'b001111, 6'b110000: begin
        x   = 5'd28;
        k28 = 1'b1;
      end
      default: begin
        x    = 5'd0;
        err6 = 1'b1;
      end
    endcase

    // K28 4b forms back to their RD- column
    f4   = (abcdei == 6'b001111) ? ~fghj : fghj;
    err4 = 1'b0;
    y    = 3'd0;
    if (k28) begin
      case (f4)
        4'b1011: y = 3'd0;
        4'b0110: y = 3'd1;
        4'b1010: y = 3'd2;
        4'b1100: y = 3'd3;
        4'b1101: y = 3'd4;
        4'b0101: y = 3'd5;
        4'b1001: y = 3'd6;
        4'b0111: y = 3'd7;
        default: err4 = 1'b1;
      endcase
    end else begin
      case (fghj)
        4'b1011, 4'b0100: y = 3'd0;
        4'b1001:          y = 3'd1;
        4'b0101:          y = 3'd2;
        4'b1100, 4'b0011: y = 3'd3;
        4'b1101, 4'b0010: y = 3'd4;
        4'b1010:          y = 3'd5;
        4'b0110:          y = 3'd6;
        4'b1110, 4'b0001, 4'b0111, 4'b1000: y = 3'd7;
        default: err4 = 1'b1;
      endcase
    end

    dec_char.k = k28 || ((x inside {5'd23, 5'd27, 5'd29, 5'd30}) &&
                         (fghj inside {4'b0111, 4'b1000}));
    dec_char.data = {y, x};

    // Unbalanced blocks and the D.07/D.x.3 pairs must match current disparity
    ones6    = 3'($countones(abcdei));
    ones4    = 3'($countones(fghj));
    disp_err = (rd && (ones6 == 3'd4 || abcdei == 6'b111000)) ||
               (!rd && (ones6 == 3'd2 || abcdei == 6'b000111));
    rd_mid   = (ones6 == 3'd3) ? rd : (ones6 > 3'd3);
    disp_err = disp_err || (rd_mid && (ones4 == 3'd3 || fghj == 4'b1100)) ||
               (!rd_mid && (ones4 == 3'd1 || fghj == 4'b0011));
    rd_next  = (ones4 == 3'd2) ? rd_mid : (ones4 > 3'd2);
    code_err = err6 || err4 || disp_err;
  end

  always_ff @(posedge bit_clk_x4) begin
    if (reset) begin
      rd    <= 1'b0;
      wr_en <= 1'b0;
    end else begin
      // Idle commas never reach the FIFO
      wr_en <= sym_valid && (dec_char != IDLE_CHAR);
      // A bad block still sets disparity so the tracker recovers
      if (sym_valid) begin
        rd <= rd_next;
      end
    end
  end

  always_ff @(posedge bit_clk_x4) begin
    if (sym_valid) begin
      wr_word <= '{code_err: code_err, ch: dec_char};
    end
  end

  // At most one write per symbol slot
  a_wr_spacing: assert property (@(posedge bit_clk_x4) disable iff (reset)
    wr_en |=> !wr_en ##1 !wr_en ##1 !wr_en ##1 !wr_en);

endmodule

//--- logic/elink_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~
// Receive FIFO
// 16 entries, drops writes when full
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module elink_fifo import elink_pkg::*; (
  input  logic           bit_clk_x4,
  input  logic           reset,
  input  logic           wr_en,
  input  elink_rx_word_t wr_word,
  input  logic           rd_en,
  output elink_rx_word_t rd_data,
  output logic           empty,
  output logic           full
);

  elink_rx_word_t   mem [FIFO_DEPTH];
  // Extra top bit tells full from empty
  logic [FIFO_AW:0] wr_ptr, rd_ptr, count;
  logic             do_wr, do_rd;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                 (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
  assign count = wr_ptr - rd_ptr;
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;
  // First-word fall-through read
  assign rd_data = mem[rd_ptr[FIFO_AW-1:0]];

  always_ff @(posedge bit_clk_x4) begin
    if (do_wr) begin
      mem[wr_ptr[FIFO_AW-1:0]] <= wr_word;
    end
  end

  always_ff @(posedge bit_clk_x4) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Reader must respect empty
  a_no_rd_empty: assert property (@(posedge bit_clk_x4) disable iff (reset)
    rd_en |-> !empty);

  // Dropped write leaves the fill level alone
  a_full_drop: assert property (@(posedge bit_clk_x4) disable iff (reset)
    wr_en && full && !rd_en |=> count == $past(count));

endmodule

//--- logic/elink_loopback_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// E-link loopback top
// Encoder and serializer looped over the 2-bit link into the receiver
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module elink_loopback_top import elink_pkg::*; (
  input  logic           bit_clk_x4,
  input  logic           reset,
  input  elink_char_t    tx_char,
  input  logic           tx_valid,
  output logic           tx_ready,
  output logic           locked,
  input  logic           rd_en,
  output elink_rx_word_t rd_data,
  output logic           empty,
  output logic           full
);

  // Transmit chain
  elink_char_t       enc_char;
  logic              enc_load;
  logic [SYM_W-1:0]  enc_sym;
  // Internal link
  logic [LINK_W-1:0] link_data;
  // Receive chain
  logic [SYM_W-1:0]  sym;
  logic              sym_valid;
  logic              wr_en;
  elink_rx_word_t    wr_word;

  // Port names match the nets here
  elink_tx_ser   i_tx_ser   (.*);
  enc_8b10b      i_enc      (.*);
  elink_rx_deser i_rx_deser (.*);
  dec_8b10b      i_dec      (.*);
  elink_fifo     i_fifo     (.*);

endmodule

//--- dv/tb_elink_loopback.sv
// ~~~~~~~~~~~~~~~~~~~~
// E-link loopback testbench
// Table and random characters through the link, FIFO read back
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_elink_loopback import elink_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int N_TBL      = 36;
  localparam int N_BP       = 20;
  localparam int N_RND      = 200;
  // All slots of all phases plus lock time, reads and margin
  localparam int WD_CYCLES  = (N_TBL + N_BP + N_RND + 60) * SLOT_CYCLES + 2 * FIFO_DEPTH + 300;

  // One slot of stimulus and whether it shows up in the FIFO
  typedef struct packed {
    logic        send;
    elink_char_t ch;
    logic        appears;
  } stim_t;

  // {send, k, data, appears}
  localparam stim_t TBL [N_TBL] = '{
    {1'b1, 1'b0, 8'h00, 1'b1}, {1'b1, 1'b0, 8'h03, 1'b1},
    {1'b1, 1'b0, 8'h07, 1'b1}, {1'b1, 1'b0, 8'h0B, 1'b1},
    {1'b1, 1'b1, 8'h1C, 1'b1}, {1'b1, 1'b0, 8'h0F, 1'b1},
    {1'b1, 1'b0, 8'h14, 1'b1}, {1'b0, 1'b0, 8'h42, 1'b0},
    {1'b1, 1'b1, 8'h3C, 1'b1}, {1'b1, 1'b0, 8'h1C, 1'b1},
    {1'b1, 1'b0, 8'h2B, 1'b1}, {1'b1, 1'b1, 8'h5C, 1'b1},
    {1'b1, 1'b1, 8'h7C, 1'b1}, {1'b1, 1'b0, 8'h55, 1'b1},
    {1'b1, 1'b1, 8'hBC, 1'b0}, {1'b1, 1'b0, 8'h6A, 1'b1},
    {1'b1, 1'b1, 8'h9C, 1'b1}, {1'b1, 1'b0, 8'h87, 1'b1},
    {1'b1, 1'b1, 8'hDC, 1'b1}, {1'b0, 1'b1, 8'h3C, 1'b0},
    {1'b1, 1'b0, 8'hA5, 1'b1}, {1'b1, 1'b1, 8'hFC, 1'b1},
    {1'b1, 1'b0, 8'hCE, 1'b1}, {1'b1, 1'b1, 8'hF7, 1'b1},
    {1'b1, 1'b0, 8'hE7, 1'b1}, {1'b1, 1'b0, 8'hEB, 1'b1},
    {1'b1, 1'b1, 8'hFB, 1'b1}, {1'b1, 1'b0, 8'hED, 1'b1},
    {1'b1, 1'b0, 8'hEE, 1'b1}, {1'b0, 1'b0, 8'h99, 1'b0},
    {1'b1, 1'b1, 8'hFD, 1'b1}, {1'b1, 1'b0, 8'hF1, 1'b1},
    {1'b1, 1'b0, 8'hF2, 1'b1}, {1'b1, 1'b1, 8'hFE, 1'b1},
    {1'b1, 1'b0, 8'hF4, 1'b1}, {1'b1, 1'b0, 8'hFF, 1'b1}
  };

  logic           clk;
  logic           reset;
  elink_char_t    tx_char;
  logic           tx_valid;
  logic           tx_ready;
  logic           locked;
  logic           rd_en;
  elink_rx_word_t rd_data;
  logic           empty;
  logic           full;

  // Words still to come out of the FIFO, oldest first
  elink_rx_word_t exp_q [$];

  elink_loopback_top i_dut (
    .bit_clk_x4 (clk),
    .reset      (reset),
    .tx_char    (tx_char),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .locked     (locked),
    .rd_en      (rd_en),
    .rd_data    (rd_data),
    .empty      (empty),
    .full       (full)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_word(input string name, input elink_rx_word_t got,
                            input elink_rx_word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "flag mismatch");
    end
  endtask

  // Offer one slot, returns on the edge that loads the encoder
  task automatic send_slot(input elink_char_t c, input logic v);
    @(posedge clk);
    tx_char  <= c;
    tx_valid <= v;
    do @(negedge clk); while (!tx_ready);
    @(posedge clk);
  endtask

  task automatic idle_slots(input int n);
    repeat (n) send_slot(IDLE_CHAR, 1'b0);
  endtask

  // Head sampled mid-cycle, then a one-cycle rd_en pulse pops it
  task automatic read_word(output elink_rx_word_t w);
    do @(negedge clk); while (empty);
    w = rd_data;
    @(posedge clk);
    rd_en <= 1'b1;
    @(posedge clk);
    rd_en <= 1'b0;
  endtask

  task automatic read_expected(input int n);
    elink_rx_word_t w;
    for (int i = 0; i < n; i++) begin
      read_word(w);
      check_word("rd_data", w, exp_q.pop_front());
    end
  endtask

  // Bounds every wait in the run
  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("[TIMEOUT] %0t watchdog expired before the tests completed", $time);
    $display("Simulation finished: FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    elink_char_t c;
    elink_char_t rnd [N_RND];
    int          n;
    void'($urandom(32'h6f045884));
    clk      = 1'b0;
    reset    = 1'b1;
    tx_char  = IDLE_CHAR;
    tx_valid = 1'b0;
    rd_en    = 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // Reset levels, then the first slot one cycle later
    @(negedge clk);
    check_flag("empty", empty, 1'b1);
    check_flag("full", full, 1'b0);
    check_flag("locked", locked, 1'b0);
    check_flag("tx_ready", tx_ready, 1'b0);
    @(negedge clk);
    check_flag("tx_ready", tx_ready, 1'b1);

    // Idles only, lock without any FIFO write
    do @(negedge clk); while (!locked);
    check_flag("empty", empty, 1'b1);
    idle_slots(8);
    check_flag("empty", empty, 1'b1);

    // Table, only offered non-idle characters expected
    for (int i = 0; i < N_TBL; i++) begin
      if (TBL[i].appears) begin
        exp_q.push_back('{code_err: 1'b0, ch: TBL[i].ch});
      end
    end
    n = exp_q.size();
    fork
      begin
        for (int i = 0; i < N_TBL; i++) begin
          send_slot(TBL[i].ch, TBL[i].send);
        end
        idle_slots(6);
      end
      read_expected(n);
    join
    check_flag("empty", empty, 1'b1);

    // Back-pressure, no reads until all 20 are sent
    for (int i = 0; i < N_BP; i++) begin
      c = '{k: 1'b0, data: 8'(i * 37 + 11)};
      if (i < FIFO_DEPTH) begin
        exp_q.push_back('{code_err: 1'b0, ch: c});
      end
      send_slot(c, 1'b1);
    end
    idle_slots(6);
    check_flag("full", full, 1'b1);
    read_expected(FIFO_DEPTH);
    @(negedge clk);
    check_flag("empty", empty, 1'b1);
    check_flag("full", full, 1'b0);

    // Random data bytes
    for (int i = 0; i < N_RND; i++) begin
      rnd[i] = '{k: 1'b0, data: 8'($urandom)};
      exp_q.push_back('{code_err: 1'b0, ch: rnd[i]});
    end
    fork
      begin
        for (int i = 0; i < N_RND; i++) begin
          send_slot(rnd[i], 1'b1);
        end
        idle_slots(6);
      end
      read_expected(N_RND);
    join
    check_flag("empty", empty, 1'b1);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- list.f
common/elink_pkg.sv
elink_tx/enc_8b10b.sv
elink_tx/elink_tx_ser.sv
elink_rx/elink_rx_deser.sv
elink_rx/dec_8b10b.sv
logic/elink_fifo.sv
logic/elink_loopback_top.sv
dv/tb_elink_loopback.sv

//--- Makefile
TOOL   = verilator
TOP    = tb_elink_loopback
FLIST  = list.f
FLAGS  = --binary --timing --assert -Wno-fatal -j 0
OBJDIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
